//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_memory_interface_unit
FILELIST  := sources.f
LOG       := sim.log
PASS_MSG  := TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- boot.hex
// boot rom image, one 32-bit word per line, word 0 first
00000297
02028293
30529073
00002537
00050513
000025b7
00458593
0005a603
00060463
0080006f
800002b7
00028067
0000006f
00000013
00000013
00000000

//--- bootloader.sv
module bootloader (
    input  logic              clk_i,
    input  logic              rst_i,

    input  mem_pkg::obi_req_t dmem_req_i,
    output mem_pkg::obi_rsp_t dmem_rsp_o,
    input  mem_pkg::obi_req_t imem_req_i,
    output mem_pkg::obi_rsp_t imem_rsp_o,

    input  logic              copy_flash_i,
    output logic              illegal_write_o
);

    logic [31:0]       rom [mem_pkg::BTLD_WORDS];
    mem_pkg::obi_req_t port_req [2];
    mem_pkg::obi_rsp_t port_rsp [2];
    logic [1:0]        bad_wr;

    initial begin
        $readmemh("boot.hex", rom);
    end

    assign port_req[0] = dmem_req_i;
    assign port_req[1] = imem_req_i;
    assign dmem_rsp_o  = port_rsp[0];
    assign imem_rsp_o  = port_rsp[1];

    // two identical read ports, 0 for dmem and 1 for imem
    for (genvar p = 0; p < 2; p++) begin : g_port
        logic        rvalid_q;
        logic [31:0] rdata_q;
        logic [$clog2(mem_pkg::BTLD_WORDS)-1:0] idx;

        assign idx = port_req[p].addr[$clog2(mem_pkg::BTLD_WORDS)+1:2];

        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                rvalid_q <= 1'b0;
            end else begin
                rvalid_q <= port_req[p].req;
            end
        end

        always_ff @(posedge clk_i) begin
            if (port_req[p].req) begin
                if (port_req[p].we) begin
                    // rom stays untouched
                    rdata_q <= mem_pkg::ERR_RDATA;
                end else if (port_req[p].addr == mem_pkg::BOOT_MODE_ADDR) begin
                    rdata_q <= {31'b0, copy_flash_i};
                end else begin
                    rdata_q <= rom[idx];
                end
            end
        end

        assign port_rsp[p] = '{gnt: 1'b1, rvalid: rvalid_q, rdata: rdata_q};
        assign bad_wr[p]   = port_req[p].req && port_req[p].we;
    end

    // flagged in the grant cycle
    assign illegal_write_o = |bad_wr;

endmodule

//--- mem_pkg.sv
package mem_pkg;

    //////////////////////////////
    // address map
    //////////////////////////////

    localparam logic [31:0] BTLD_BASE   = 32'h0000_0000;
    localparam logic [31:0] BTLD_END    = 32'h0000_0fff;
    localparam logic [31:0] SRAM_BASE   = 32'h8000_0000;
    localparam logic [31:0] SRAM_END    = 32'h8000_ffff;
    localparam logic [31:0] FLASH_BASE  = 32'h2000_0000;
    localparam logic [31:0] FLASH_END   = 32'h3fff_ffff;
    localparam logic [31:0] PERIPH_BASE = 32'h1000_0000;
    localparam logic [31:0] PERIPH_END  = 32'h1000_1fff;

    // last rom word holds the boot mode
    localparam logic [31:0] BOOT_MODE_ADDR = BTLD_BASE + 32'd60;
    localparam int          BTLD_WORDS     = 16;

    localparam logic [31:0] ERR_RDATA  = 32'hdead_beef;
    localparam int          RESP_DEPTH = 2;

    //////////////////////////////
    // OBI channel
    //////////////////////////////

    typedef struct packed {
        logic        req;
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } obi_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } obi_rsp_t;

    typedef enum logic [2:0] {
        TGT_BTLD,
        TGT_SRAM,
        TGT_FLASH,
        TGT_PERIPH,
        TGT_ERR
    } target_e;

    typedef enum logic {
        ACC_READ,
        ACC_WRITE
    } access_e;

endpackage

//--- memory_interface_unit.sv
module memory_interface_unit (
    input  logic              clk_i,
    input  logic              rst_i,

    input  mem_pkg::obi_req_t dmem_req_i,
    output mem_pkg::obi_rsp_t dmem_rsp_o,
    input  mem_pkg::obi_req_t imem_req_i,
    output mem_pkg::obi_rsp_t imem_rsp_o,

    output mem_pkg::obi_req_t sram_d_req_o,
    input  mem_pkg::obi_rsp_t sram_d_rsp_i,
    output mem_pkg::obi_req_t sram_i_req_o,
    input  mem_pkg::obi_rsp_t sram_i_rsp_i,
    output mem_pkg::obi_req_t flash_req_o,
    input  mem_pkg::obi_rsp_t flash_rsp_i,
    output mem_pkg::obi_req_t periph_req_o,
    input  mem_pkg::obi_rsp_t periph_rsp_i,

    input  logic              copy_flash_i,
    output logic              illegal_access_o
);

    mem_pkg::obi_req_t btld_d_req, btld_i_req;
    mem_pkg::obi_rsp_t btld_d_rsp, btld_i_rsp;
    logic              illegal_xbar;
    logic              illegal_boot;

    //////////////////////////////
    // crossbar
    //////////////////////////////

    obi_xbar u_xbar (
        .clk_i,
        .rst_i,
        .dmem_req_i,
        .dmem_rsp_o,
        .imem_req_i,
        .imem_rsp_o,
        .sram_d_req_o,
        .sram_d_rsp_i,
        .sram_i_req_o,
        .sram_i_rsp_i,
        .flash_req_o,
        .flash_rsp_i,
        .periph_req_o,
        .periph_rsp_i,
        .btld_d_req_o (btld_d_req),
        .btld_d_rsp_i (btld_d_rsp),
        .btld_i_req_o (btld_i_req),
        .btld_i_rsp_i (btld_i_rsp),
        .illegal_o    (illegal_xbar)
    );

    //////////////////////////////
    // boot rom
    //////////////////////////////

    bootloader u_btld (
        .clk_i,
        .rst_i,
        .dmem_req_i      (btld_d_req),
        .dmem_rsp_o      (btld_d_rsp),
        .imem_req_i      (btld_i_req),
        .imem_rsp_o      (btld_i_rsp),
        .copy_flash_i,
        .illegal_write_o (illegal_boot)
    );

    assign illegal_access_o = illegal_xbar || illegal_boot;

endmodule

//--- memory_interface_unit_assert.sv
module memory_interface_unit_assert (
    input logic              clk_i,
    input logic              rst_i,
    input mem_pkg::obi_req_t dmem_req_i,
    input mem_pkg::obi_rsp_t dmem_rsp_i,
    input mem_pkg::obi_req_t imem_req_i,
    input mem_pkg::obi_rsp_t imem_rsp_i,
    input logic              d_tgt_rvalid_i,
    input logic              i_tgt_rvalid_i,
    input logic              d_empty_i,
    input logic              i_empty_i,
    input logic              illegal_i
);

    // request must hold until granted
    a_dmem_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        dmem_req_i.req && !dmem_rsp_i.gnt |=> dmem_req_i.req && $stable(dmem_req_i))
        else $error("dmem request changed before gnt");

    a_imem_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        imem_req_i.req && !imem_rsp_i.gnt |=> imem_req_i.req && $stable(imem_req_i))
        else $error("imem request changed before gnt");

    // target side answers only for a tracked transaction
    a_dmem_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
        d_tgt_rvalid_i |-> !d_empty_i)
        else $error("target answered dmem with nothing outstanding");

    a_imem_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
        i_tgt_rvalid_i |-> !i_empty_i)
        else $error("target answered imem with nothing outstanding");

    // an illegal grant is answered with the error word one cycle later
    a_illegal_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
        illegal_i |=> (dmem_rsp_i.rvalid && dmem_rsp_i.rdata == mem_pkg::ERR_RDATA) ||
                      (imem_rsp_i.rvalid && imem_rsp_i.rdata == mem_pkg::ERR_RDATA))
        else $error("illegal grant without an error response one cycle later");

endmodule

bind obi_xbar memory_interface_unit_assert u_assert (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .dmem_req_i     (dmem_req_i),
    .dmem_rsp_i     (dmem_rsp_o),
    .imem_req_i     (imem_req_i),
    .imem_rsp_i     (imem_rsp_o),
    .d_tgt_rvalid_i (sram_d_rsp_i.rvalid || periph_rsp_i.rvalid ||
                     btld_d_rsp_i.rvalid || flash_d_rsp.rvalid),
    .i_tgt_rvalid_i (sram_i_rsp_i.rvalid || btld_i_rsp_i.rvalid || flash_i_rsp.rvalid),
    .d_empty_i      (d_empty),
    .i_empty_i      (i_empty),
    .illegal_i      (illegal_o)
);

//--- obi_addr_decode.sv
module obi_addr_decode (
    input  logic              [31:0] addr_i,
    input  logic                     we_i,
    input  logic                     is_imem_i,
    output mem_pkg::target_e         target_o,
    output logic                     illegal_o
);

    mem_pkg::target_e hit;
    mem_pkg::access_e acc;

    function automatic logic in_range(logic [31:0] a, logic [31:0] lo, logic [31:0] hi);
        return (a >= lo) && (a <= hi);
    endfunction

    assign acc = we_i ? mem_pkg::ACC_WRITE : mem_pkg::ACC_READ;

    always_comb begin
        if (in_range(addr_i, mem_pkg::BTLD_BASE, mem_pkg::BTLD_END)) begin
            hit = mem_pkg::TGT_BTLD;
        end else if (in_range(addr_i, mem_pkg::SRAM_BASE, mem_pkg::SRAM_END)) begin
            hit = mem_pkg::TGT_SRAM;
        end else if (in_range(addr_i, mem_pkg::FLASH_BASE, mem_pkg::FLASH_END)) begin
            hit = mem_pkg::TGT_FLASH;
        end else if (in_range(addr_i, mem_pkg::PERIPH_BASE, mem_pkg::PERIPH_END)) begin
            hit = mem_pkg::TGT_PERIPH;
        end else begin
            hit = mem_pkg::TGT_ERR;
        end
    end

    always_comb begin
        illegal_o = (hit == mem_pkg::TGT_ERR);
        // read-only regions
        if (acc == mem_pkg::ACC_WRITE &&
            (hit == mem_pkg::TGT_FLASH || hit == mem_pkg::TGT_BTLD)) begin
            illegal_o = 1'b1;
        end
        // fetch port only reads, never reaches peripherals
        if (is_imem_i && (acc == mem_pkg::ACC_WRITE || hit == mem_pkg::TGT_PERIPH)) begin
            illegal_o = 1'b1;
        end
        target_o = illegal_o ? mem_pkg::TGT_ERR : hit;
    end

endmodule

//--- obi_resp_router.sv
module obi_resp_router (
    input  logic              clk_i,
    input  logic              rst_i,

    input  logic              push_i,
    input  mem_pkg::target_e  push_tgt_i,
    output logic              room_o,
    output mem_pkg::target_e  last_tgt_o,
    output logic              empty_o,

    input  mem_pkg::obi_rsp_t sram_rsp_i,
    input  mem_pkg::obi_rsp_t flash_rsp_i,
    input  mem_pkg::obi_rsp_t periph_rsp_i,
    input  mem_pkg::obi_rsp_t btld_rsp_i,
    output mem_pkg::obi_rsp_t rsp_o
);

    typedef logic [$clog2(mem_pkg::RESP_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(mem_pkg::RESP_DEPTH+1)-1:0] cnt_t;

    mem_pkg::target_e tgt_q [mem_pkg::RESP_DEPTH];
    ptr_t             wr_q;
    ptr_t             rd_q;
    cnt_t             cnt_q;
    logic             err_q;
    logic             pop;
    mem_pkg::target_e head;

    assign head       = tgt_q[rd_q];
    assign last_tgt_o = tgt_q[wr_q - ptr_t'(1)];
    assign empty_o    = (cnt_q == '0);
    assign room_o     = (cnt_q != cnt_t'(mem_pkg::RESP_DEPTH));
    assign pop        = rsp_o.rvalid;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_q  <= '0;
            rd_q  <= '0;
            cnt_q <= '0;
            err_q <= 1'b0;
        end else begin
            // error answer is due the cycle after its grant
            err_q <= push_i && (push_tgt_i == mem_pkg::TGT_ERR);
            if (push_i) begin
                wr_q <= wr_q + ptr_t'(1);
            end
            if (pop) begin
                rd_q <= rd_q + ptr_t'(1);
            end
            if (push_i && !pop) begin
                cnt_q <= cnt_q + cnt_t'(1);
            end else if (pop && !push_i) begin
                cnt_q <= cnt_q - cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            tgt_q[wr_q] <= push_tgt_i;
        end
    end

    // steer the head target's response
    always_comb begin
        rsp_o = '0;
        if (!empty_o) begin
            case (head)
                mem_pkg::TGT_SRAM: begin
                    rsp_o.rvalid = sram_rsp_i.rvalid;
                    rsp_o.rdata  = sram_rsp_i.rdata;
                end
                mem_pkg::TGT_FLASH: begin
                    rsp_o.rvalid = flash_rsp_i.rvalid;
                    rsp_o.rdata  = flash_rsp_i.rdata;
                end
                mem_pkg::TGT_PERIPH: begin
                    rsp_o.rvalid = periph_rsp_i.rvalid;
                    rsp_o.rdata  = periph_rsp_i.rdata;
                end
                mem_pkg::TGT_BTLD: begin
                    rsp_o.rvalid = btld_rsp_i.rvalid;
                    rsp_o.rdata  = btld_rsp_i.rdata;
                end
                default: begin
                    rsp_o.rvalid = err_q;
                    rsp_o.rdata  = mem_pkg::ERR_RDATA;
                end
            endcase
        end
    end

endmodule

//--- obi_xbar.sv
module obi_xbar (
    input  logic              clk_i,
    input  logic              rst_i,

    input  mem_pkg::obi_req_t dmem_req_i,
    output mem_pkg::obi_rsp_t dmem_rsp_o,
    input  mem_pkg::obi_req_t imem_req_i,
    output mem_pkg::obi_rsp_t imem_rsp_o,

    output mem_pkg::obi_req_t sram_d_req_o,
    input  mem_pkg::obi_rsp_t sram_d_rsp_i,
    output mem_pkg::obi_req_t sram_i_req_o,
    input  mem_pkg::obi_rsp_t sram_i_rsp_i,
    output mem_pkg::obi_req_t flash_req_o,
    input  mem_pkg::obi_rsp_t flash_rsp_i,
    output mem_pkg::obi_req_t periph_req_o,
    input  mem_pkg::obi_rsp_t periph_rsp_i,
    output mem_pkg::obi_req_t btld_d_req_o,
    input  mem_pkg::obi_rsp_t btld_d_rsp_i,
    output mem_pkg::obi_req_t btld_i_req_o,
    input  mem_pkg::obi_rsp_t btld_i_rsp_i,

    output logic              illegal_o
);

    typedef logic [$clog2(2 * mem_pkg::RESP_DEPTH)-1:0] own_ptr_t;

    mem_pkg::target_e  d_tgt, i_tgt, d_last, i_last;
    logic              d_ill, i_ill;
    logic              d_room, i_room, d_empty, i_empty;
    logic              d_go, i_go;
    logic              d_flash, i_flash, i_flash_sel;
    logic              d_tgt_gnt, i_tgt_gnt;
    logic              d_gnt, i_gnt;
    logic              i_own_q;
    mem_pkg::obi_rsp_t d_rsp, i_rsp;
    mem_pkg::obi_rsp_t flash_d_rsp, flash_i_rsp;
    mem_pkg::obi_rsp_t no_rsp;

    // flash response owners, 1 means imem
    logic              own_q [2 * mem_pkg::RESP_DEPTH];
    own_ptr_t          own_wr_q, own_rd_q;

    //////////////////////////////
    // decode and issue check
    //////////////////////////////

    obi_addr_decode u_dec_d (
        .addr_i    (dmem_req_i.addr),
        .we_i      (dmem_req_i.we),
        .is_imem_i (1'b0),
        .target_o  (d_tgt),
        .illegal_o (d_ill)
    );

    obi_addr_decode u_dec_i (
        .addr_i    (imem_req_i.addr),
        .we_i      (imem_req_i.we),
        .is_imem_i (1'b1),
        .target_o  (i_tgt),
        .illegal_o (i_ill)
    );

    // hold off while the router is full or busy with another target
    assign d_go = dmem_req_i.req && d_room && (d_empty || d_last == d_tgt);
    assign i_go = imem_req_i.req && i_room && (i_empty || i_last == i_tgt);

    //////////////////////////////
    // flash arbitration
    //////////////////////////////

    assign d_flash = d_go && (d_tgt == mem_pkg::TGT_FLASH);
    assign i_flash = i_go && (i_tgt == mem_pkg::TGT_FLASH);

    // dmem first, unless imem is already waiting on flash gnt
    assign i_flash_sel = i_flash && (i_own_q || !d_flash);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            i_own_q  <= 1'b0;
            own_wr_q <= '0;
            own_rd_q <= '0;
        end else begin
            i_own_q <= i_flash_sel && !flash_rsp_i.gnt;
            if (flash_req_o.req && flash_rsp_i.gnt) begin
                own_wr_q <= own_wr_q + own_ptr_t'(1);
            end
            if (flash_rsp_i.rvalid) begin
                own_rd_q <= own_rd_q + own_ptr_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (flash_req_o.req && flash_rsp_i.gnt) begin
            own_q[own_wr_q] <= i_flash_sel;
        end
    end

    always_comb begin
        flash_d_rsp        = flash_rsp_i;
        flash_i_rsp        = flash_rsp_i;
        flash_d_rsp.rvalid = flash_rsp_i.rvalid && !own_q[own_rd_q];
        flash_i_rsp.rvalid = flash_rsp_i.rvalid && own_q[own_rd_q];
    end

    //////////////////////////////
    // request forwarding
    //////////////////////////////

    always_comb begin
        sram_d_req_o     = dmem_req_i;
        sram_d_req_o.req = d_go && (d_tgt == mem_pkg::TGT_SRAM);
        btld_d_req_o     = dmem_req_i;
        btld_d_req_o.req = d_go && (d_tgt == mem_pkg::TGT_BTLD);
        periph_req_o     = dmem_req_i;
        periph_req_o.req = d_go && (d_tgt == mem_pkg::TGT_PERIPH);
        sram_i_req_o     = imem_req_i;
        sram_i_req_o.req = i_go && (i_tgt == mem_pkg::TGT_SRAM);
        btld_i_req_o     = imem_req_i;
        btld_i_req_o.req = i_go && (i_tgt == mem_pkg::TGT_BTLD);
        flash_req_o      = i_flash_sel ? imem_req_i : dmem_req_i;
        flash_req_o.req  = d_flash || i_flash;
    end

    // illegal requests take the default, granted without a target
    always_comb begin
        case (d_tgt)
            mem_pkg::TGT_SRAM:   d_tgt_gnt = sram_d_rsp_i.gnt;
            mem_pkg::TGT_BTLD:   d_tgt_gnt = btld_d_rsp_i.gnt;
            mem_pkg::TGT_FLASH:  d_tgt_gnt = flash_rsp_i.gnt && !i_flash_sel;
            mem_pkg::TGT_PERIPH: d_tgt_gnt = periph_rsp_i.gnt;
            default:             d_tgt_gnt = 1'b1;
        endcase
        case (i_tgt)
            mem_pkg::TGT_SRAM:   i_tgt_gnt = sram_i_rsp_i.gnt;
            mem_pkg::TGT_BTLD:   i_tgt_gnt = btld_i_rsp_i.gnt;
            mem_pkg::TGT_FLASH:  i_tgt_gnt = flash_rsp_i.gnt && i_flash_sel;
            default:             i_tgt_gnt = 1'b1;
        endcase
    end

    assign d_gnt = d_go && d_tgt_gnt;
    assign i_gnt = i_go && i_tgt_gnt;

    assign illegal_o = (d_gnt && d_ill) || (i_gnt && i_ill);

    //////////////////////////////
    // response return
    //////////////////////////////

    assign no_rsp = '0;

    obi_resp_router u_rsp_d (
        .clk_i,
        .rst_i,
        .push_i       (d_gnt),
        .push_tgt_i   (d_tgt),
        .room_o       (d_room),
        .last_tgt_o   (d_last),
        .empty_o      (d_empty),
        .sram_rsp_i   (sram_d_rsp_i),
        .flash_rsp_i  (flash_d_rsp),
        .periph_rsp_i (periph_rsp_i),
        .btld_rsp_i   (btld_d_rsp_i),
        .rsp_o        (d_rsp)
    );

    obi_resp_router u_rsp_i (
        .clk_i,
        .rst_i,
        .push_i       (i_gnt),
        .push_tgt_i   (i_tgt),
        .room_o       (i_room),
        .last_tgt_o   (i_last),
        .empty_o      (i_empty),
        .sram_rsp_i   (sram_i_rsp_i),
        .flash_rsp_i  (flash_i_rsp),
        .periph_rsp_i (no_rsp),
        .btld_rsp_i   (btld_i_rsp_i),
        .rsp_o        (i_rsp)
    );

    assign dmem_rsp_o = '{gnt: d_gnt, rvalid: d_rsp.rvalid, rdata: d_rsp.rdata};
    assign imem_rsp_o = '{gnt: i_gnt, rvalid: i_rsp.rvalid, rdata: i_rsp.rdata};

endmodule

//--- sources.f
mem_pkg.sv
obi_addr_decode.sv
obi_resp_router.sv
obi_xbar.sv
bootloader.sv
memory_interface_unit.sv
tb_target_model.sv
memory_interface_unit_assert.sv
tb_memory_interface_unit.sv

//--- tb_memory_interface_unit.sv
module tb_memory_interface_unit;

    typedef struct {
        logic              mgr;
        mem_pkg::access_e  acc;
        logic [31:0]       addr;
        logic [3:0]        be;
        logic [31:0]       wdata;
        logic              copy;
        logic              ill;
        int                batch;
    } entry_t;

    logic              clk_i = 1'b0;
    logic              rst_i;
    logic              copy_flash_i;
    logic              illegal_access_o;
    mem_pkg::obi_req_t dmem_req, imem_req;
    mem_pkg::obi_rsp_t dmem_rsp, imem_rsp;
    mem_pkg::obi_req_t tgt_req [4];
    mem_pkg::obi_rsp_t tgt_rsp [4];
    logic [1:0]        delay [4];

    logic [31:0] lfsr_q = 32'h44e26b41;
    logic [31:0] ref_mem [4][64];
    logic [31:0] boot_ref [16];
    entry_t      tbl [$];
    entry_t      issue_q0 [$], issue_q1 [$];
    logic [31:0] exp_q0 [$], exp_q1 [$];
    int          inflight = 0;
    int          cycle_cnt = 0;
    int          err_cnt = 0;
    int          d_last_cyc, i_last_cyc;

    always #10 clk_i = ~clk_i;

    memory_interface_unit dut (
        .clk_i, .rst_i,
        .dmem_req_i (dmem_req), .dmem_rsp_o (dmem_rsp),
        .imem_req_i (imem_req), .imem_rsp_o (imem_rsp),
        .sram_d_req_o (tgt_req[0]), .sram_d_rsp_i (tgt_rsp[0]),
        .sram_i_req_o (tgt_req[1]), .sram_i_rsp_i (tgt_rsp[1]),
        .flash_req_o  (tgt_req[2]), .flash_rsp_i  (tgt_rsp[2]),
        .periph_req_o (tgt_req[3]), .periph_rsp_i (tgt_rsp[3]),
        .copy_flash_i, .illegal_access_o
    );

    // 0 sram-d, 1 sram-i, 2 flash, 3 peripheral
    tb_target_model u_sram_d (.clk_i, .rst_i, .req_i(tgt_req[0]), .rsp_o(tgt_rsp[0]),
                              .delay_i(delay[0]));
    tb_target_model u_sram_i (.clk_i, .rst_i, .req_i(tgt_req[1]), .rsp_o(tgt_rsp[1]),
                              .delay_i(delay[1]));
    tb_target_model u_flash  (.clk_i, .rst_i, .req_i(tgt_req[2]), .rsp_o(tgt_rsp[2]),
                              .delay_i(delay[2]));
    tb_target_model u_periph (.clk_i, .rst_i, .req_i(tgt_req[3]), .rsp_o(tgt_rsp[3]),
                              .delay_i(delay[3]));

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic mem_pkg::target_e region(input logic [31:0] a);
        if (a <= mem_pkg::BTLD_END) return mem_pkg::TGT_BTLD;
        if (a >= mem_pkg::SRAM_BASE && a <= mem_pkg::SRAM_END) return mem_pkg::TGT_SRAM;
        if (a >= mem_pkg::FLASH_BASE && a <= mem_pkg::FLASH_END) return mem_pkg::TGT_FLASH;
        if (a >= mem_pkg::PERIPH_BASE && a <= mem_pkg::PERIPH_END) return mem_pkg::TGT_PERIPH;
        return mem_pkg::TGT_ERR;
    endfunction

    // reference model applying writes to its own copy
    task automatic predict(input entry_t e, output logic [31:0] exp);
        mem_pkg::target_e t;
        logic             wr;
        int               k;
        t  = region(e.addr);
        wr = (e.acc == mem_pkg::ACC_WRITE);
        k  = (t == mem_pkg::TGT_FLASH) ? 2 : (t == mem_pkg::TGT_PERIPH) ? 3 : int'(e.mgr);
        if (t == mem_pkg::TGT_ERR ||
            (wr && (t == mem_pkg::TGT_FLASH || t == mem_pkg::TGT_BTLD)) ||
            (e.mgr && (wr || t == mem_pkg::TGT_PERIPH))) begin
            exp = mem_pkg::ERR_RDATA;
        end else if (t == mem_pkg::TGT_BTLD) begin
            exp = (e.addr == mem_pkg::BOOT_MODE_ADDR) ? {31'b0, e.copy} : boot_ref[e.addr[5:2]];
        end else if (wr) begin
            for (int b = 0; b < 4; b++) begin
                if (e.be[b]) ref_mem[k][e.addr[7:2]][8*b +: 8] = e.wdata[8*b +: 8];
            end
            exp = '0;
        end else begin
            exp = ref_mem[k][e.addr[7:2]];
        end
    endtask

    task automatic check_rsp(input string name, input mem_pkg::obi_rsp_t got,
                             input logic [31:0] exp);
        if (got.rdata !== exp) begin
            err_cnt++;
            fail_now($sformatf("FAILED t=%0t %s.rdata got=%h exp=%h",
                               $time, name, got.rdata, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            fail_now($sformatf("FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp));
        end
    endtask

    task automatic add(input logic mgr, input mem_pkg::access_e acc, input logic [31:0] addr,
                       input logic [3:0] be, input logic [31:0] wdata, input logic copy,
                       input logic ill, input int batch);
        entry_t e;
        e = '{mgr, acc, addr, be, wdata, copy, ill, batch};
        tbl.push_back(e);
    endtask

    // one request at a time per manager until gnt
    task automatic drive_port(input int m);
        entry_t            e;
        logic [31:0]       exp;
        mem_pkg::obi_req_t r;
        forever begin
            @(posedge clk_i);
            #2;
            r = '0;
            if ((m == 0 && issue_q0.size() > 0) || (m == 1 && issue_q1.size() > 0)) begin
                e = (m == 0) ? issue_q0.pop_front() : issue_q1.pop_front();
                r = '{1'b1, e.acc == mem_pkg::ACC_WRITE, e.be, e.addr, e.wdata};
                if (m == 0) dmem_req = r;
                else imem_req = r;
                @(negedge clk_i);
                while (!(m == 0 ? dmem_rsp.gnt : imem_rsp.gnt)) begin
                    @(negedge clk_i);
                end
                predict(e, exp);
                if (m == 0) exp_q0.push_back(exp);
                else exp_q1.push_back(exp);
                check_flag("illegal_access_o", illegal_access_o, e.ill);
            end else if (m == 0) begin
                dmem_req = r;
            end else begin
                imem_req = r;
            end
        end
    endtask

    //////////////////////////////
    // monitors
    //////////////////////////////

    always @(posedge clk_i) begin
        logic [31:0] v;
        #2;
        for (int k = 0; k < 4; k++) begin
            v = draw_bits(2);
            delay[k] = (v[1:0] == 2'd3) ? 2'd2 : v[1:0];
        end
    end

    always @(posedge clk_i) begin
        if (!rst_i) begin
            cycle_cnt++;
            if (cycle_cnt > 40 * tbl.size()) fail_now("timeout, requests did not complete");
        end
    end

    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (illegal_access_o && !(dmem_rsp.gnt || imem_rsp.gnt))
                fail_now("illegal_access_o raised without a grant");
            if (dmem_rsp.rvalid) begin
                if (exp_q0.size() == 0) fail_now("dmem response with no request outstanding");
                check_rsp("dmem_rsp_o", dmem_rsp, exp_q0.pop_front());
                d_last_cyc = cycle_cnt;
                inflight--;
            end
            if (imem_rsp.rvalid) begin
                if (exp_q1.size() == 0) fail_now("imem response with no request outstanding");
                check_rsp("imem_rsp_o", imem_rsp, exp_q1.pop_front());
                i_last_cyc = cycle_cnt;
                inflight--;
            end
        end
    end

    initial drive_port(0);
    initial drive_port(1);

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    initial begin
        int          idx;
        int          b;
        int          nd;
        int          ni;
        logic        all_flash;
        logic [31:0] v;
        rst_i        = 1'b1;
        copy_flash_i = 1'b0;
        dmem_req     = '0;
        imem_req     = '0;
        for (int k = 0; k < 4; k++) delay[k] = '0;
        $readmemh("boot.hex", boot_ref);
        for (int i = 0; i < 64; i++) begin
            for (int k = 0; k < 4; k++) begin
                v = draw_bits(32);
                ref_mem[k][i] = v;
                case (k)
                    0: u_sram_d.load_word(i, v);
                    1: u_sram_i.load_word(i, v);
                    2: u_flash.load_word(i, v);
                    default: u_periph.load_word(i, v);
                endcase
            end
        end

        add(0, mem_pkg::ACC_READ,  32'h8000_0010, 4'hf, 0, 0, 0, 1);
        add(0, mem_pkg::ACC_WRITE, 32'h8000_0010, 4'h5, 32'h1122_3344, 0, 0, 2);
        add(0, mem_pkg::ACC_READ,  32'h8000_0010, 4'hf, 0, 0, 0, 3);
        add(0, mem_pkg::ACC_READ,  32'h2000_0008, 4'hf, 0, 0, 0, 4);
        add(0, mem_pkg::ACC_WRITE, 32'h1000_0004, 4'hf, 32'hcafe_f00d, 0, 0, 5);
        add(0, mem_pkg::ACC_READ,  32'h1000_0004, 4'hf, 0, 0, 0, 6);
        add(1, mem_pkg::ACC_READ,  32'h8000_0020, 4'hf, 0, 0, 0, 7);
        add(1, mem_pkg::ACC_READ,  32'h0000_0004, 4'hf, 0, 0, 0, 8);
        add(1, mem_pkg::ACC_READ,  mem_pkg::BOOT_MODE_ADDR, 4'hf, 0, 1, 0, 9);
        add(0, mem_pkg::ACC_READ,  mem_pkg::BOOT_MODE_ADDR, 4'hf, 0, 0, 0, 10);
        // illegal accesses
        add(0, mem_pkg::ACC_READ,  32'h5000_0000, 4'hf, 0, 0, 1, 11);
        add(0, mem_pkg::ACC_WRITE, 32'h2000_0000, 4'hf, 32'h1, 0, 1, 12);
        add(0, mem_pkg::ACC_WRITE, 32'h0000_0008, 4'hf, 32'h2, 0, 1, 13);
        add(1, mem_pkg::ACC_READ,  32'h1000_0000, 4'hf, 0, 0, 1, 14);
        // both managers on flash in one cycle
        add(0, mem_pkg::ACC_READ,  32'h2000_0040, 4'hf, 0, 0, 0, 15);
        add(1, mem_pkg::ACC_READ,  32'h2000_0044, 4'hf, 0, 0, 0, 15);
        // back to back across targets
        add(0, mem_pkg::ACC_WRITE, 32'h8000_0030, 4'hc, 32'h89ab_cdef, 0, 0, 16);
        add(0, mem_pkg::ACC_READ,  32'h2000_0010, 4'hf, 0, 0, 0, 16);
        add(0, mem_pkg::ACC_READ,  32'h1000_0004, 4'hf, 0, 0, 0, 16);
        add(0, mem_pkg::ACC_READ,  32'h8000_0030, 4'hf, 0, 0, 0, 16);
        add(0, mem_pkg::ACC_READ,  32'h0000_000c, 4'hf, 0, 0, 0, 16);
        add(1, mem_pkg::ACC_READ,  32'h8000_0004, 4'hf, 0, 0, 0, 16);
        add(1, mem_pkg::ACC_READ,  32'h0000_0010, 4'hf, 0, 0, 0, 16);

        repeat (16) @(posedge clk_i);
        #2;
        rst_i = 1'b0;

        idx = 0;
        while (idx < tbl.size()) begin
            b            = tbl[idx].batch;
            copy_flash_i = tbl[idx].copy;
            nd           = 0;
            ni           = 0;
            all_flash    = 1'b1;
            while (idx < tbl.size() && tbl[idx].batch == b) begin
                if (region(tbl[idx].addr) != mem_pkg::TGT_FLASH) all_flash = 1'b0;
                if (tbl[idx].mgr) begin
                    issue_q1.push_back(tbl[idx]);
                    ni++;
                end else begin
                    issue_q0.push_back(tbl[idx]);
                    nd++;
                end
                inflight++;
                idx++;
            end
            while (inflight != 0) @(negedge clk_i);
            // dmem has priority on a shared target
            if (nd > 0 && ni > 0 && all_flash && d_last_cyc > i_last_cyc)
                fail_now("imem flash response came before the dmem one");
        end

        repeat (2) @(posedge clk_i);
        if (err_cnt == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            fail_now("errors were recorded");
        end
    end

endmodule

//--- tb_target_model.sv
module tb_target_model #(
    parameter int WORDS = 64
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  mem_pkg::obi_req_t req_i,
    output mem_pkg::obi_rsp_t rsp_o,
    // cycles of gnt to withhold, at most 2
    input  logic [1:0]        delay_i
);

    logic [31:0] mem [WORDS];
    logic [1:0]  wait_q;
    logic        gnt;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic [5:0]  idx;

    assign idx   = req_i.addr[7:2];
    assign gnt   = req_i.req && (wait_q >= delay_i);
    assign rsp_o = '{gnt: gnt, rvalid: rvalid_q, rdata: rdata_q};

    always @(posedge clk_i) begin
        if (rst_i) begin
            wait_q   <= '0;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= gnt;
            if (req_i.req && !gnt) begin
                wait_q <= wait_q + 2'd1;
            end else begin
                wait_q <= '0;
            end
            if (gnt) begin
                if (req_i.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req_i.be[b]) begin
                            mem[idx][8*b +: 8] = req_i.wdata[8*b +: 8];
                        end
                    end
                    // writes answer with zero data
                    rdata_q <= '0;
                end else begin
                    rdata_q <= mem[idx];
                end
            end
        end
    end

    task automatic load_word(input int i, input logic [31:0] v);
        mem[i] = v;
    endtask

endmodule
